// ==== logic/mips_pkg.sv ====
package mips_pkg;

    // r-format view of an instruction word.
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target26;
    } j_fields_t;

    // one fetched word, read through whichever format the opcode selects.
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_word_t;

    typedef enum logic [4:0] {
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_JR,
        OP_ADDIU,
        OP_ANDI,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_INVALID  // runs as a no-op.
    } op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_LUI
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_SEQ,     // pc + 4.
        PC_BRANCH,  // pc + 4 + (imm16 << 2).
        PC_JUMP,    // upper bits with target26.
        PC_REG      // rs value.
    } pc_sel_t;

endpackage

// ==== logic/mem_bus_if.sv ====
`timescale 1ns/1ps

// request/done link between a memory requester and the arbiter.
interface mem_bus_if;
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;  // valid in the done cycle of a read.
    logic        done;   // one cycle per transfer.

    modport requester (
        output req, we, addr, wdata,
        input  rdata, done
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, done
    );
endinterface

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_t op,
    output logic [31:0]       result,
    output logic              zero
);
    import mips_pkg::*;

    logic slt_bit;

    assign slt_bit = $signed(a) < $signed(b);  // signed compare.

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'd0, slt_bit};
            // shifts act on the rt operand.
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_LUI: result = {b[15:0], 16'h0000};
            default: result = a + b;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  rs_idx,
    input  logic [4:0]  rt_idx,
    input  logic [4:0]  rd_idx,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && rd_idx != 5'd0) begin
            regs[rd_idx] <= wdata;  // register 0 stays zero.
        end
    end

    // reads are combinational.
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];
    assign v0      = regs[2];

endmodule

// ==== logic/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fetch_start,
    input  logic                  pc_update,
    input  mips_pkg::pc_sel_t     pc_sel,
    input  logic [31:0]           rs_value,
    mem_bus_if.requester          bus,
    output mips_pkg::instr_word_t instr,
    output logic                  fetched,
    output logic [31:0]           pc_plus4,
    output logic                  halted
);
    import mips_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] pc_next;
    logic [31:0] branch_offset;
    logic        req_q;
    instr_word_t ir_q;

    assign pc_plus4      = pc_q + 32'd4;
    assign branch_offset = {{14{ir_q.i.imm16[15]}}, ir_q.i.imm16, 2'b00};

    always_comb begin
        case (pc_sel)
            PC_BRANCH: pc_next = pc_plus4 + branch_offset;
            PC_JUMP:   pc_next = {pc_plus4[31:28], ir_q.j.target26, 2'b00};
            PC_REG:    pc_next = rs_value;
            default:   pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q   <= RESET_VECTOR;
            halted <= 1'b0;
            req_q  <= 1'b0;
        end else begin
            req_q <= (req_q | fetch_start) & ~bus.done;
            if (pc_update) begin
                pc_q <= pc_next;
                // jr to address zero ends the program.
                if (pc_sel == PC_REG && rs_value == 32'd0) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.done) begin
            ir_q <= bus.rdata;
        end
    end

    // the read goes out in the same cycle as fetch_start.
    assign bus.req   = req_q | fetch_start;
    assign bus.we    = 1'b0;
    assign bus.addr  = pc_q;
    assign bus.wdata = 32'd0;
    assign instr     = ir_q;
    assign fetched   = bus.done;

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        bus.req && !bus.done |=> bus.req)
        else $error("instruction read request dropped before done.");

endmodule

// ==== logic/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         start,
    input  logic         store,
    input  logic [31:0]  addr,
    input  logic [31:0]  store_data,
    mem_bus_if.requester bus,
    output logic [31:0]  load_data,
    output logic         complete
);

    logic        req_q;
    logic        we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [31:0] data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q <= 1'b0;
        end else if (start) begin
            req_q <= 1'b1;
        end else if (bus.done) begin
            req_q <= 1'b0;
        end
    end

    // request fields, captured once and held until done.
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            we_q    <= store;
            wdata_q <= store_data;
        end
        if (bus.done && !we_q) begin
            data_q <= bus.rdata;  // keep the last loaded word.
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = we_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    // the word is needed in the done cycle itself for the register write.
    assign load_data = bus.done ? bus.rdata : data_q;
    assign complete  = bus.done;

    no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !req_q)
        else $error("data access started while one is still outstanding.");

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic        clk,
    input  logic        arst_n,
    mem_bus_if.arbiter  fetch_bus,
    mem_bus_if.arbiter  data_bus,
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    output logic [31:0] writedata,
    input  logic        waitrequest,
    input  logic [31:0] readdata
);

    logic busy_q;      // a transfer is stalled by waitrequest.
    logic owner_q;     // 1 means the load/store unit owns the port.
    logic owner_data;
    logic cmd;
    logic xfer_done;

    // a new grant favours data accesses, a stalled one keeps its owner.
    assign owner_data = busy_q ? owner_q : data_bus.req;
    assign cmd        = owner_data ? data_bus.req : fetch_bus.req;
    assign xfer_done  = cmd & ~waitrequest;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else begin
            busy_q  <= cmd & waitrequest;
            owner_q <= owner_data;
        end
    end

    assign address   = owner_data ? data_bus.addr : fetch_bus.addr;
    assign writedata = owner_data ? data_bus.wdata : fetch_bus.wdata;
    assign read      = cmd & ~(owner_data ? data_bus.we : fetch_bus.we);
    assign write     = cmd & (owner_data ? data_bus.we : fetch_bus.we);

    assign fetch_bus.rdata = readdata;
    assign data_bus.rdata  = readdata;
    assign fetch_bus.done  = xfer_done & ~owner_data;
    assign data_bus.done   = xfer_done & owner_data;

    one_command: assert property (@(posedge clk) disable iff (!arst_n)
        !(read && write))
        else $error("read and write asserted together.");

    cmd_held: assert property (@(posedge clk) disable iff (!arst_n)
        cmd && waitrequest |=> cmd && $stable(address) && $stable(write)
                               && $stable(writedata))
        else $error("stalled command changed before completion.");

endmodule

// ==== logic/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mips_pkg::instr_word_t instr,
    input  logic                  fetched,
    input  logic                  halted,
    input  logic                  ls_complete,
    input  logic                  alu_zero,
    output logic                  fetch_start,
    output logic                  pc_update,
    output mips_pkg::pc_sel_t     pc_sel,
    output logic                  ls_start,
    output logic                  ls_store,
    output mips_pkg::alu_op_t     alu_op,
    output logic                  alu_b_imm,
    output logic [31:0]           imm_value,
    output logic [4:0]            rs_idx,
    output logic [4:0]            rt_idx,
    output logic [4:0]            rd_idx,
    output logic                  reg_we,
    output logic                  reg_from_load,
    output logic                  active
);
    import mips_pkg::*;

    typedef enum logic [1:0] {S_FETCH, S_EXEC1, S_EXEC2, S_HALT} state_t;

    state_t      state;
    op_t         op;
    logic        fetch_issued;
    logic        writes_reg;
    logic        is_mem;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;

    always_comb begin
        case (instr.r.opcode)
            6'h00: begin  // special, decoded by funct.
                case (instr.r.funct)
                    6'h21:   op = OP_ADDU;
                    6'h23:   op = OP_SUBU;
                    6'h24:   op = OP_AND;
                    6'h25:   op = OP_OR;
                    6'h26:   op = OP_XOR;
                    6'h2a:   op = OP_SLT;
                    6'h00:   op = OP_SLL;
                    6'h02:   op = OP_SRL;
                    6'h08:   op = OP_JR;
                    default: op = OP_INVALID;
                endcase
            end
            6'h09:   op = OP_ADDIU;
            6'h0c:   op = OP_ANDI;
            6'h0d:   op = OP_ORI;
            6'h0f:   op = OP_LUI;
            6'h23:   op = OP_LW;
            6'h2b:   op = OP_SW;
            6'h04:   op = OP_BEQ;
            6'h05:   op = OP_BNE;
            6'h02:   op = OP_J;
            default: op = OP_INVALID;
        endcase
    end

    assign imm_sext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign imm_zext = {16'h0000, instr.i.imm16};

    always_comb begin
        alu_op     = ALU_ADD;
        alu_b_imm  = 1'b0;
        imm_value  = imm_sext;
        rd_idx     = instr.r.rd;
        writes_reg = 1'b0;
        is_mem     = 1'b0;
        case (op)
            OP_ADDU: writes_reg = 1'b1;
            OP_SUBU: begin
                alu_op     = ALU_SUB;
                writes_reg = 1'b1;
            end
            OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL, OP_SRL: begin
                alu_op     = (op == OP_AND) ? ALU_AND : (op == OP_OR) ? ALU_OR :
                             (op == OP_XOR) ? ALU_XOR : (op == OP_SLT) ? ALU_SLT :
                             (op == OP_SLL) ? ALU_SLL : ALU_SRL;
                writes_reg = 1'b1;
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
                alu_op     = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR :
                             (op == OP_LUI) ? ALU_LUI : ALU_ADD;
                imm_value  = (op == OP_ADDIU) ? imm_sext : imm_zext;
                alu_b_imm  = 1'b1;
                rd_idx     = instr.i.rt;
                writes_reg = 1'b1;
            end
            OP_LW, OP_SW: begin  // address is rs + offset.
                alu_b_imm = 1'b1;
                rd_idx    = (op == OP_LW) ? instr.i.rt : 5'd0;
                is_mem    = 1'b1;
            end
            OP_BEQ, OP_BNE: alu_op = ALU_SUB;  // compare through the zero flag.
            default: rd_idx = 5'd0;
        endcase
    end

    // branch decision kept apart from the alu controls it feeds back from.
    always_comb begin
        case (op)
            OP_BEQ:  pc_sel = alu_zero ? PC_BRANCH : PC_SEQ;
            OP_BNE:  pc_sel = alu_zero ? PC_SEQ : PC_BRANCH;
            OP_J:    pc_sel = PC_JUMP;
            OP_JR:   pc_sel = PC_REG;
            default: pc_sel = PC_SEQ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state        <= S_FETCH;
            fetch_issued <= 1'b0;
        end else begin
            if (fetched) begin
                fetch_issued <= 1'b0;
            end else if (fetch_start) begin
                fetch_issued <= 1'b1;
            end
            case (state)
                S_FETCH: begin
                    if (halted) begin
                        state <= S_HALT;
                    end else if (fetched) begin
                        state <= S_EXEC1;
                    end
                end
                S_EXEC1: state <= is_mem ? S_EXEC2 : S_FETCH;
                S_EXEC2: begin
                    if (ls_complete) begin
                        state <= S_FETCH;
                    end
                end
                default: state <= S_HALT;
            endcase
        end
    end

    assign fetch_start   = (state == S_FETCH) && !fetch_issued && !halted;
    assign pc_update     = (state == S_EXEC1);
    assign ls_start      = (state == S_EXEC1) && is_mem;
    assign ls_store      = (op == OP_SW);
    assign rs_idx        = instr.r.rs;
    assign rt_idx        = instr.r.rt;
    assign reg_from_load = (state == S_EXEC2);
    assign reg_we        = ((state == S_EXEC1) && writes_reg) ||
                           ((state == S_EXEC2) && (op == OP_LW) && ls_complete);
    assign active        = ~halted;

    no_r0_write: assert property (@(posedge clk) disable iff (!arst_n)
        reg_we |-> rd_idx != 5'd0)
        else $error("register write aimed at register zero.");

endmodule

// ==== logic/mips_cpu_bus.sv ====
`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        arst_n,
    output logic        active,
    output logic [31:0] register_v0,

    // avalon master port.
    output logic [31:0] address,
    output logic        read,
    output logic        write,
    input  logic        waitrequest,
    output logic [31:0] writedata,
    input  logic [31:0] readdata
);

    mips_pkg::instr_word_t instr;
    mips_pkg::pc_sel_t     pc_sel;
    mips_pkg::alu_op_t     alu_op;

    logic        fetched, halted, fetch_start, pc_update;
    logic        ls_start, ls_store, ls_complete;
    logic        alu_b_imm, alu_zero, reg_we, reg_from_load;
    logic [4:0]  rs_idx, rt_idx, rd_idx;
    logic [31:0] imm_value, rs_data, rt_data, alu_result, load_data;

    mem_bus_if if_bus ();
    mem_bus_if ls_bus ();

    fetch_unit #(
        .RESET_VECTOR(RESET_VECTOR)
    ) u_fetch (
        .clk(clk), .arst_n(arst_n),
        .fetch_start(fetch_start), .pc_update(pc_update),
        .pc_sel(pc_sel), .rs_value(rs_data),
        .bus(if_bus.requester),
        .instr(instr), .fetched(fetched),
        .pc_plus4(), .halted(halted)
    );

    load_store_unit u_lsu (
        .clk(clk), .arst_n(arst_n),
        .start(ls_start), .store(ls_store),
        .addr(alu_result), .store_data(rt_data),
        .bus(ls_bus.requester),
        .load_data(load_data), .complete(ls_complete)
    );

    bus_arbiter u_arbiter (
        .clk(clk), .arst_n(arst_n),
        .fetch_bus(if_bus.arbiter), .data_bus(ls_bus.arbiter),
        .address(address), .read(read), .write(write),
        .writedata(writedata),
        .waitrequest(waitrequest), .readdata(readdata)
    );

    control_unit u_control (
        .clk(clk), .arst_n(arst_n),
        .instr(instr), .fetched(fetched), .halted(halted),
        .ls_complete(ls_complete), .alu_zero(alu_zero),
        .fetch_start(fetch_start), .pc_update(pc_update), .pc_sel(pc_sel),
        .ls_start(ls_start), .ls_store(ls_store),
        .alu_op(alu_op), .alu_b_imm(alu_b_imm), .imm_value(imm_value),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rd_idx(rd_idx),
        .reg_we(reg_we), .reg_from_load(reg_from_load),
        .active(active)
    );

    alu u_alu (
        .a(rs_data),
        .b(alu_b_imm ? imm_value : rt_data),
        .shamt(instr.r.shamt),
        .op(alu_op),
        .result(alu_result),
        .zero(alu_zero)
    );

    register_file u_regs (
        .clk(clk), .arst_n(arst_n),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rd_idx(rd_idx),
        .we(reg_we),
        .wdata(reg_from_load ? load_data : alu_result),
        .rs_data(rs_data), .rt_data(rt_data),
        .v0(register_v0)
    );

endmodule

// ==== testbench/tb_mips_cpu_bus.sv ====
`timescale 1ns/1ps

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0400;
    localparam int          MEM_WORDS    = 1024;
    localparam int          HALT_LIMIT   = 40000;

    logic        clk;
    logic        arst_n;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        read;
    logic        write;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [31:0] readdata;

    logic [31:0] mem     [MEM_WORDS];  // memory seen by the DUT.
    logic [31:0] ref_mem [MEM_WORDS];  // memory of the instruction-set model.
    logic [63:0] exp_stores [$];       // {address, data} in program order.
    logic [31:0] exp_v0;
    logic [31:0] gen_lfsr;
    logic [31:0] wait_lfsr;
    logic [31:0] gen_addr;
    logic        stalled;
    logic        held_write;
    logic [31:0] held_addr;
    logic [31:0] held_data;
    int          checks;
    int          errors;
    int          tests;

    mips_cpu_bus #(
        .RESET_VECTOR(RESET_VECTOR)
    ) uut (
        .clk(clk), .arst_n(arst_n),
        .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write),
        .waitrequest(waitrequest), .writedata(writedata), .readdata(readdata)
    );

    always #20 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int k = 0; k < n; k++) begin
            gen_lfsr = lfsr_step(gen_lfsr);
            v = {v[30:0], gen_lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_store(input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] exp_addr, input logic [31:0] exp_data);
        checks++;
        if (addr !== exp_addr || data !== exp_data) begin
            $display("error at time %0t: store %h <- %h, expected %h <- %h",
                     $time, addr, data, exp_addr, exp_data);
            errors++;
        end
    endtask

    task automatic log_store(input logic [31:0] addr, input logic [31:0] data);
        logic [63:0] e;
        if (exp_stores.size() == 0) begin
            $display("unexpected write of %h to address %h at time %0t", data, addr, $time);
            errors++;
        end else begin
            e = exp_stores.pop_front();
            check_store(addr, data, e[63:32], e[31:0]);
        end
    endtask

    // avalon slave, zero read latency, at least one wait cycle per command.
    always @(posedge clk) begin
        if (!arst_n) begin
            waitrequest <= 1'b1;
            stalled = 1'b0;
        end else begin
            check_flag("read and write together", read && write, 1'b0);
            if (stalled) begin
                check_flag("command held under waitrequest", read || write, 1'b1);
                check_flag("direction held under waitrequest", write, held_write);
                check_word("address held under waitrequest", address, held_addr);
                if (held_write) begin
                    check_word("writedata held under waitrequest", writedata, held_data);
                end
            end
            if ((read || write) && !waitrequest) begin
                if (write) begin
                    mem[address[11:2]] = writedata;
                    log_store(address, writedata);
                end
                waitrequest <= 1'b1;
                stalled = 1'b0;
            end else if (read || write) begin
                readdata <= mem[address[11:2]];
                wait_lfsr = lfsr_step(wait_lfsr);
                waitrequest <= wait_lfsr[0];
                stalled = 1'b1;
                held_addr = address;
                held_write = write;
                held_data = writedata;
            end else begin
                waitrequest <= 1'b1;
                stalled = 1'b0;
            end
        end
    end

    function automatic instr_word_t enc_r(input logic [5:0] funct, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] shamt);
        instr_word_t w;
        w.r.opcode = 6'h00;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = shamt;
        w.r.funct  = funct;
        return w;
    endfunction

    function automatic instr_word_t enc_i(input logic [5:0] opcode, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        instr_word_t w;
        w.i.opcode = opcode;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm16  = imm;
        return w;
    endfunction

    function automatic instr_word_t enc_j(input logic [25:0] target);
        instr_word_t w;
        w.j.opcode   = 6'h02;
        w.j.target26 = target;
        return w;
    endfunction

    task automatic put(input instr_word_t w);
        mem[gen_addr[11:2]] = w;
        gen_addr = gen_addr + 32'd4;
    endtask

    function automatic op_t pick_op(input int kind);
        logic [3:0] r;
        op_t        op;
        r = rand_bits(4);
        if (kind == 0 || r < 4'd12) begin
            case (r % 4'd12)
                4'd0:    op = OP_ADDU;
                4'd1:    op = OP_SUBU;
                4'd2:    op = OP_AND;
                4'd3:    op = OP_OR;
                4'd4:    op = OP_XOR;
                4'd5:    op = OP_SLT;
                4'd6:    op = OP_SLL;
                4'd7:    op = OP_SRL;
                4'd8:    op = OP_ADDIU;
                4'd9:    op = OP_ANDI;
                4'd10:   op = OP_ORI;
                default: op = OP_LUI;
            endcase
        end else if (kind == 1) begin
            op = r[0] ? OP_LW : OP_SW;
        end else begin
            case (r)
                4'd12:   op = OP_BEQ;
                4'd13:   op = OP_BNE;
                4'd14:   op = OP_J;
                default: op = OP_JR;
            endcase
        end
        return op;
    endfunction

    // r28 holds the data base, r26 the jr target, r29 the halt register.
    task automatic emit_op(input op_t op);
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sh;
        logic [15:0] imm;
        rd  = 5'd1 + 5'(rand_bits(4) % 15);
        rs  = rand_bits(4);
        rt  = rand_bits(4);
        sh  = rand_bits(5);
        imm = rand_bits(16);
        case (op)
            OP_ADDU:  put(enc_r(6'h21, rs, rt, rd, 5'd0));
            OP_SUBU:  put(enc_r(6'h23, rs, rt, rd, 5'd0));
            OP_AND:   put(enc_r(6'h24, rs, rt, rd, 5'd0));
            OP_OR:    put(enc_r(6'h25, rs, rt, rd, 5'd0));
            OP_XOR:   put(enc_r(6'h26, rs, rt, rd, 5'd0));
            OP_SLT:   put(enc_r(6'h2a, rs, rt, rd, 5'd0));
            OP_SLL:   put(enc_r(6'h00, 5'd0, rt, rd, sh));
            OP_SRL:   put(enc_r(6'h02, 5'd0, rt, rd, sh));
            OP_ADDIU: put(enc_i(6'h09, rs, rd, imm));
            OP_ANDI:  put(enc_i(6'h0c, rs, rd, imm));
            OP_ORI:   put(enc_i(6'h0d, rs, rd, imm));
            OP_LUI:   put(enc_i(6'h0f, 5'd0, rd, imm));
            OP_LW:    put(enc_i(6'h23, 5'd28, rd, {8'd0, imm[5:0], 2'b00}));
            default:  put(enc_i(6'h2b, 5'd28, rt, {8'd0, imm[5:0], 2'b00}));
        endcase
    endtask

    // forward only, skipping `skip` words after the jump itself.
    task automatic emit_flow(input op_t op, input logic [15:0] skip);
        logic [31:0] target;
        logic [4:0]  rs;
        logic [4:0]  rt;
        rs = rand_bits(4);
        rt = rand_bits(4);
        if (op == OP_JR) begin
            target = gen_addr + 32'd8 + 4 * skip;
            put(enc_i(6'h0d, 5'd0, 5'd26, target[15:0]));
            put(enc_r(6'h08, 5'd26, 5'd0, 5'd0, 5'd0));
        end else if (op == OP_J) begin
            target = gen_addr + 32'd4 + 4 * skip;
            put(enc_j(target[27:2]));
        end else begin
            put(enc_i((op == OP_BEQ) ? 6'h04 : 6'h05, rs, rt, skip));
        end
    endtask

    task automatic build_program(input int kind);
        op_t         op;
        logic [15:0] skip;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9e37_79b9) ^ 32'h0bad_f00d;
        end
        gen_addr = RESET_VECTOR;
        put(enc_i(6'h0d, 5'd0, 5'd28, 16'h0800));  // data region base.
        for (int n = 0; n < 28; n++) begin
            op = pick_op(kind);
            if (op == OP_BEQ || op == OP_BNE || op == OP_J || op == OP_JR) begin
                skip = 16'd1 + 16'(rand_bits(2) % 3);
                emit_flow(op, skip);
                emit_op(OP_SW);  // marker on the path that may be skipped.
                for (int k = 1; k < skip; k++) begin
                    emit_op(pick_op(0));
                end
            end else begin
                emit_op(op);
            end
        end
        put(enc_r(6'h21, 5'd0, 5'd0, 5'd29, 5'd0));
        put(enc_r(6'h08, 5'd29, 5'd0, 5'd0, 5'd0));
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = mem[i];
        end
    endtask

    // instruction-set model, no delay slots.
    task automatic run_model();
        logic [31:0] regs_m [32];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] ea;
        instr_word_t w;
        int          steps;
        logic        done;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = 32'd0;
        end
        exp_stores.delete();
        pc    = RESET_VECTOR;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 5000) begin
            w    = ref_mem[pc[11:2]];
            a    = regs_m[w.r.rs];
            b    = regs_m[w.r.rt];
            sext = {{16{w.i.imm16[15]}}, w.i.imm16};
            ea   = a + sext;
            npc  = pc + 32'd4;
            case (w.r.opcode)
                6'h00: begin
                    case (w.r.funct)
                        6'h21: regs_m[w.r.rd] = a + b;
                        6'h23: regs_m[w.r.rd] = a - b;
                        6'h24: regs_m[w.r.rd] = a & b;
                        6'h25: regs_m[w.r.rd] = a | b;
                        6'h26: regs_m[w.r.rd] = a ^ b;
                        6'h2a: regs_m[w.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h00: regs_m[w.r.rd] = b << w.r.shamt;
                        6'h02: regs_m[w.r.rd] = b >> w.r.shamt;
                        6'h08: begin
                            npc  = a;
                            done = (a == 32'd0);
                        end
                        default: ;
                    endcase
                end
                6'h09: regs_m[w.i.rt] = ea;
                6'h0c: regs_m[w.i.rt] = a & {16'h0000, w.i.imm16};
                6'h0d: regs_m[w.i.rt] = a | {16'h0000, w.i.imm16};
                6'h0f: regs_m[w.i.rt] = {w.i.imm16, 16'h0000};
                6'h23: regs_m[w.i.rt] = ref_mem[ea[11:2]];
                6'h2b: begin
                    ref_mem[ea[11:2]] = b;
                    exp_stores.push_back({ea, b});
                end
                6'h04: if (a == b) npc = pc + 32'd4 + {sext[29:0], 2'b00};
                6'h05: if (a != b) npc = pc + 32'd4 + {sext[29:0], 2'b00};
                6'h02: npc = {npc[31:28], w.j.target26, 2'b00};
                default: ;
            endcase
            regs_m[0] = 32'd0;
            pc = npc;
            steps++;
        end
        if (!done) begin
            $display("the model never reached the halting jr");
            errors++;
        end
        exp_v0 = regs_m[2];
    endtask

    task automatic run_test(input int kind, input string name);
        int          start_errors;
        int          cycles;
        start_errors = errors;
        @(posedge clk);
        arst_n <= 1'b0;
        build_program(kind);
        run_model();
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!(read || write) && cycles < 100) begin
            check_flag("active before the first command", active, 1'b1);
            @(negedge clk);
            cycles++;
        end
        if (!(read || write)) begin
            $display("the core issued no bus command within 100 cycles after reset");
            errors++;
        end
        check_flag("first command is a read", read && !write, 1'b1);
        check_word("first command address", address, RESET_VECTOR);
        cycles = 0;
        while (active && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("timeout: the core did not halt within %0d cycles in test %0d",
                     HALT_LIMIT, tests);
            $display("SIMULATION FAILED");
            $finish;
        end
        check_word("register_v0 at halt", register_v0, exp_v0);
        repeat (200) begin
            @(negedge clk);
            check_flag("bus command after halt", read || write, 1'b0);
        end
        check_flag("active after halt", active, 1'b0);
        check_word("register_v0 after idle", register_v0, exp_v0);
        if (exp_stores.size() != 0) begin
            $display("%0d expected stores never reached the bus", exp_stores.size());
            errors++;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("memory word %0d", i), mem[i], ref_mem[i]);
        end
        tests++;
        $display("test %0d (%s) finished with %0d errors", tests, name, errors - start_errors);
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        waitrequest = 1'b1;
        readdata    = 32'd0;
        gen_lfsr    = 32'hfe30_6915;
        wait_lfsr   = 32'hfe30_6915;
        stalled     = 1'b0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        for (int t = 0; t < 4; t++) begin
            run_test(0, "alu");
        end
        for (int t = 0; t < 4; t++) begin
            run_test(1, "load/store");
        end
        for (int t = 0; t < 4; t++) begin
            run_test(2, "branch/jump");
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
logic/mips_pkg.sv
logic/mem_bus_if.sv
logic/alu.sv
logic/register_file.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/control_unit.sv
logic/mips_cpu_bus.sv
testbench/tb_mips_cpu_bus.sv
